// File: src/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_word_t;

    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    // SAVE registers follow on from SAVE0
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    localparam int CRMD_IE_BIT   = 2;
    localparam int PRMD_PIE_BIT  = 2;
    localparam int EENTRY_VA_LSB = 6;
    localparam int TICLR_CLR_BIT = 0;

    typedef union packed {
        csr_word_t raw;
        struct packed {
            logic [29:0] initval;
            logic        periodic;
            logic        en;
        } tcfg;
        struct packed {
            logic        rsvd31;
            logic [8:0]  esubcode;
            logic [5:0]  ecode;
            logic [2:0]  rsvd15;
            logic [12:0] is;
        } estat;
    } csr_word_u;

    // Masked write merge
    function automatic csr_word_t csr_merge(input csr_word_t old_val, input csr_word_t mask,
                                            input csr_word_t value);
        return (mask & value) | (~mask & old_val);
    endfunction

endpackage

`default_nettype wire

// File: src/csr_exc_pkg.sv
`default_nettype none

package csr_exc_pkg;

    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;
    typedef logic [1:0] plv_t;

    // Address error codes, these write BADV
    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam esubcode_t ESUBCODE_ADEF = 9'h000;

    localparam int INT_NUM    = 13;
    localparam int HW_INT_NUM = 8;
    localparam int INT_TIMER  = 11;
    localparam int INT_IPI    = 12;

endpackage

`default_nettype wire

// File: src/csr_exc_regs.sv
`default_nettype none

module csr_exc_regs (
    input  wire                            clk,
    input  wire                            reset,
    input  wire csr_addr_pkg::csr_num_t    csr_num,
    input  wire                            csr_we,
    input  wire csr_addr_pkg::csr_word_t   csr_wmask,
    input  wire csr_addr_pkg::csr_word_t   csr_wvalue,
    input  wire                            wb_ex,
    input  wire csr_exc_pkg::ecode_t       wb_ecode,
    input  wire csr_exc_pkg::esubcode_t    wb_esubcode,
    input  wire csr_addr_pkg::csr_word_t   wb_pc,
    input  wire csr_addr_pkg::csr_word_t   wb_vaddr,
    input  wire                            ertn_flush,
    output csr_exc_pkg::plv_t              crmd_plv,
    output logic                           crmd_ie,
    output csr_exc_pkg::plv_t              prmd_pplv,
    output logic                           prmd_pie,
    output csr_addr_pkg::csr_word_t        era,
    output csr_addr_pkg::csr_word_t        badv,
    output csr_addr_pkg::csr_word_t        eentry,
    output csr_exc_pkg::ecode_t            estat_ecode,
    output csr_exc_pkg::esubcode_t         estat_esubcode,
    output csr_addr_pkg::csr_word_t        ex_entry
);
    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    logic [31-EENTRY_VA_LSB:0] eentry_va;
    csr_word_t                 crmd_new;
    csr_word_t                 prmd_new;
    logic                      addr_err;

    assign crmd_new = csr_merge({29'b0, crmd_ie, crmd_plv}, csr_wmask, csr_wvalue);
    assign prmd_new = csr_merge({29'b0, prmd_pie, prmd_pplv}, csr_wmask, csr_wvalue);
    assign addr_err = (wb_ecode == ECODE_ALE) || (wb_ecode == ECODE_ADE);

    assign eentry   = {eentry_va, {EENTRY_VA_LSB{1'b0}}};
    // No TLB refill path, every exception goes to EENTRY
    assign ex_entry = eentry;

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == CSR_CRMD) begin
            crmd_plv <= crmd_new[1:0];
            crmd_ie  <= crmd_new[CRMD_IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_num == CSR_PRMD) begin
            prmd_pplv <= prmd_new[1:0];
            prmd_pie  <= prmd_new[PRMD_PIE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era            <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wb_ex) begin
            era            <= wb_pc;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end else if (csr_we && csr_num == CSR_ERA) begin
            era <= csr_merge(era, csr_wmask, csr_wvalue);
        end
    end

    // Fetch errors report the PC, data errors the access address
    always_ff @(posedge clk) begin
        if (reset) begin
            badv <= '0;
        end else if (wb_ex && addr_err) begin
            badv <= (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) ? wb_pc : wb_vaddr;
        end else if (csr_we && csr_num == CSR_BADV) begin
            badv <= csr_merge(badv, csr_wmask, csr_wvalue);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_va <= '0;
        end else if (csr_we && csr_num == CSR_EENTRY) begin
            eentry_va <= csr_wmask[31:EENTRY_VA_LSB] & csr_wvalue[31:EENTRY_VA_LSB]
                       | ~csr_wmask[31:EENTRY_VA_LSB] & eentry_va;
        end
    end

endmodule

`default_nettype wire

// File: src/csr_int_ctrl.sv
`default_nettype none

module csr_int_ctrl (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire csr_addr_pkg::csr_num_t         csr_num,
    input  wire                                 csr_we,
    input  wire csr_addr_pkg::csr_word_t        csr_wmask,
    input  wire csr_addr_pkg::csr_word_t        csr_wvalue,
    input  wire [csr_exc_pkg::HW_INT_NUM-1:0]   hw_int_in,
    input  wire                                 ipi_int_in,
    input  wire                                 timer_zero,
    input  wire                                 crmd_ie,
    output logic [csr_exc_pkg::INT_NUM-1:0]     ecfg_lie,
    output logic [csr_exc_pkg::INT_NUM-1:0]     estat_is,
    output logic                                has_int
);
    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    csr_word_t ecfg_new;
    csr_word_u estat_new;
    logic      ticlr_clr;

    assign ecfg_new      = csr_merge({19'b0, ecfg_lie}, csr_wmask, csr_wvalue);
    assign estat_new.raw = csr_merge({19'b0, estat_is}, csr_wmask, csr_wvalue);
    assign ticlr_clr     = csr_we && csr_num == CSR_TICLR
                         && csr_wmask[TICLR_CLR_BIT] && csr_wvalue[TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (csr_we && csr_num == CSR_ECFG) begin
            // LIE bit 10 is reserved
            ecfg_lie <= {ecfg_new[12:11], 1'b0, ecfg_new[9:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is <= '0;
        end else begin
            if (csr_we && csr_num == CSR_ESTAT)
                estat_is[1:0] <= estat_new.estat.is[1:0];
            estat_is[HW_INT_NUM+1:2] <= hw_int_in;
            estat_is[10]             <= 1'b0;
            // Timer set beats a same-cycle clear
            if (timer_zero)
                estat_is[INT_TIMER] <= 1'b1;
            else if (ticlr_clr)
                estat_is[INT_TIMER] <= 1'b0;
            estat_is[INT_IPI] <= ipi_int_in;
        end
    end

    assign has_int = crmd_ie && |(ecfg_lie & estat_is);

endmodule

`default_nettype wire

// File: src/csr_timer_cfg.sv
`default_nettype none

module csr_timer_cfg (
    input  wire                            clk,
    input  wire                            reset,
    input  wire csr_addr_pkg::csr_num_t    csr_num,
    input  wire                            csr_we,
    input  wire csr_addr_pkg::csr_word_t   csr_wmask,
    input  wire csr_addr_pkg::csr_word_t   csr_wvalue,
    output logic                           tcfg_en,
    output logic                           tcfg_periodic,
    output logic [29:0]                    tcfg_initval,
    output logic                           timer_load,
    output csr_addr_pkg::csr_word_t        timer_load_value
);
    import csr_addr_pkg::*;

    csr_word_u tcfg_q;
    csr_word_u tcfg_new;
    logic      tcfg_wr;

    assign tcfg_wr      = csr_we && csr_num == CSR_TCFG;
    assign tcfg_new.raw = csr_merge(tcfg_q.raw, csr_wmask, csr_wvalue);

    always_ff @(posedge clk) begin
        if (reset)
            tcfg_q <= '0;
        else if (tcfg_wr)
            tcfg_q <= tcfg_new;
    end

    assign tcfg_en       = tcfg_q.tcfg.en;
    assign tcfg_periodic = tcfg_q.tcfg.periodic;
    assign tcfg_initval  = tcfg_q.tcfg.initval;

    // Count starts at initval scaled by four
    assign timer_load       = tcfg_wr && tcfg_new.tcfg.en;
    assign timer_load_value = {tcfg_new.tcfg.initval, 2'b00};

endmodule

`default_nettype wire

// File: src/csr_timer.sv
`default_nettype none

module csr_timer (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            timer_load,
    input  wire csr_addr_pkg::csr_word_t   timer_load_value,
    input  wire                            tcfg_en,
    input  wire                            tcfg_periodic,
    input  wire [29:0]                     tcfg_initval,
    output csr_addr_pkg::csr_word_t        timer_value,
    output logic                           timer_zero
);

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_value <= '1;
        end else if (timer_load) begin
            timer_value <= timer_load_value;
        end else if (tcfg_en && timer_value != '1) begin
            // One-shot wraps to all ones and parks there
            if (timer_zero && tcfg_periodic)
                timer_value <= {tcfg_initval, 2'b00};
            else
                timer_value <= timer_value - 32'd1;
        end
    end

    assign timer_zero = (timer_value == '0);

endmodule

`default_nettype wire

// File: src/csr_scratch_regs.sv
`default_nettype none

module csr_scratch_regs #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire csr_addr_pkg::csr_num_t               csr_num,
    input  wire                                       csr_we,
    input  wire csr_addr_pkg::csr_word_t              csr_wmask,
    input  wire csr_addr_pkg::csr_word_t              csr_wvalue,
    input  wire csr_addr_pkg::csr_word_t              coreid_in,
    output csr_addr_pkg::csr_word_t [SAVE_COUNT-1:0]  save_data,
    output csr_addr_pkg::csr_word_t                   tid
);
    import csr_addr_pkg::*;

    for (genvar i = 0; i < SAVE_COUNT; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (reset)
                save_data[i] <= '0;
            else if (csr_we && csr_num == csr_num_t'(CSR_SAVE0 + i))
                save_data[i] <= csr_merge(save_data[i], csr_wmask, csr_wvalue);
        end
    end

    // TID comes up as the core number
    always_ff @(posedge clk) begin
        if (reset)
            tid <= coreid_in;
        else if (csr_we && csr_num == CSR_TID)
            tid <= csr_merge(tid, csr_wmask, csr_wvalue);
    end

endmodule

`default_nettype wire

// File: src/csr_read_mux.sv
`default_nettype none

module csr_read_mux #(
    parameter int SAVE_COUNT = 4
) (
    input  wire csr_addr_pkg::csr_num_t                   csr_num,
    input  wire csr_exc_pkg::plv_t                        crmd_plv,
    input  wire                                           crmd_ie,
    input  wire csr_exc_pkg::plv_t                        prmd_pplv,
    input  wire                                           prmd_pie,
    input  wire [csr_exc_pkg::INT_NUM-1:0]                ecfg_lie,
    input  wire [csr_exc_pkg::INT_NUM-1:0]                estat_is,
    input  wire csr_exc_pkg::ecode_t                      estat_ecode,
    input  wire csr_exc_pkg::esubcode_t                   estat_esubcode,
    input  wire csr_addr_pkg::csr_word_t                  era,
    input  wire csr_addr_pkg::csr_word_t                  badv,
    input  wire csr_addr_pkg::csr_word_t                  eentry,
    input  wire csr_addr_pkg::csr_word_t [SAVE_COUNT-1:0] save_data,
    input  wire csr_addr_pkg::csr_word_t                  tid,
    input  wire                                           tcfg_en,
    input  wire                                           tcfg_periodic,
    input  wire [29:0]                                    tcfg_initval,
    input  wire csr_addr_pkg::csr_word_t                  timer_value,
    output csr_addr_pkg::csr_word_t                       csr_rvalue
);
    import csr_addr_pkg::*;

    csr_word_u estat_word;
    csr_word_u tcfg_word;

    always_comb begin
        estat_word                = '0;
        estat_word.estat.esubcode = estat_esubcode;
        estat_word.estat.ecode    = estat_ecode;
        estat_word.estat.is       = estat_is;
        tcfg_word                 = '0;
        tcfg_word.tcfg.initval    = tcfg_initval;
        tcfg_word.tcfg.periodic   = tcfg_periodic;
        tcfg_word.tcfg.en         = tcfg_en;
    end

    always_comb begin
        csr_rvalue = '0;
        case (csr_num)
            CSR_CRMD:   csr_rvalue = {29'b0, crmd_ie, crmd_plv};
            CSR_PRMD:   csr_rvalue = {29'b0, prmd_pie, prmd_pplv};
            CSR_ECFG:   csr_rvalue = {19'b0, ecfg_lie};
            CSR_ESTAT:  csr_rvalue = estat_word.raw;
            CSR_ERA:    csr_rvalue = era;
            CSR_BADV:   csr_rvalue = badv;
            CSR_EENTRY: csr_rvalue = eentry;
            CSR_TID:    csr_rvalue = tid;
            CSR_TCFG:   csr_rvalue = tcfg_word.raw;
            CSR_TVAL:   csr_rvalue = timer_value;
            CSR_TICLR:  csr_rvalue = '0;
            default: begin
                // SAVE window, anything else reads zero
                for (int i = 0; i < SAVE_COUNT; i++) begin
                    if (csr_num == csr_num_t'(CSR_SAVE0 + i))
                        csr_rvalue = save_data[i];
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/csr_top.sv
`default_nettype none

module csr_top #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire csr_addr_pkg::csr_num_t              csr_num,
    input  wire                                      csr_we,
    input  wire csr_addr_pkg::csr_word_t             csr_wmask,
    input  wire csr_addr_pkg::csr_word_t             csr_wvalue,
    input  wire                                      wb_ex,
    input  wire csr_exc_pkg::ecode_t                 wb_ecode,
    input  wire csr_exc_pkg::esubcode_t              wb_esubcode,
    input  wire csr_addr_pkg::csr_word_t             wb_pc,
    input  wire csr_addr_pkg::csr_word_t             wb_vaddr,
    input  wire                                      ertn_flush,
    input  wire [csr_exc_pkg::HW_INT_NUM-1:0]        hw_int_in,
    input  wire                                      ipi_int_in,
    input  wire csr_addr_pkg::csr_word_t             coreid_in,
    output csr_addr_pkg::csr_word_t                  csr_rvalue,
    output logic                                     has_int,
    output csr_addr_pkg::csr_word_t                  ex_entry
);
    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    plv_t                         crmd_plv;
    logic                         crmd_ie;
    plv_t                         prmd_pplv;
    logic                         prmd_pie;
    csr_word_t                    era;
    csr_word_t                    badv;
    csr_word_t                    eentry;
    ecode_t                       estat_ecode;
    esubcode_t                    estat_esubcode;
    logic [INT_NUM-1:0]           ecfg_lie;
    logic [INT_NUM-1:0]           estat_is;
    logic                         tcfg_en;
    logic                         tcfg_periodic;
    logic [29:0]                  tcfg_initval;
    logic                         timer_load;
    csr_word_t                    timer_load_value;
    csr_word_t                    timer_value;
    logic                         timer_zero;
    csr_word_t [SAVE_COUNT-1:0]   save_data;
    csr_word_t                    tid;

    csr_exc_regs u_exc_regs (
        .clk, .reset, .csr_num, .csr_we, .csr_wmask, .csr_wvalue,
        .wb_ex, .wb_ecode, .wb_esubcode, .wb_pc, .wb_vaddr, .ertn_flush,
        .crmd_plv, .crmd_ie, .prmd_pplv, .prmd_pie, .era, .badv, .eentry,
        .estat_ecode, .estat_esubcode, .ex_entry
    );

    csr_int_ctrl u_int_ctrl (
        .clk, .reset, .csr_num, .csr_we, .csr_wmask, .csr_wvalue,
        .hw_int_in, .ipi_int_in, .timer_zero, .crmd_ie,
        .ecfg_lie, .estat_is, .has_int
    );

    csr_timer_cfg u_timer_cfg (
        .clk, .reset, .csr_num, .csr_we, .csr_wmask, .csr_wvalue,
        .tcfg_en, .tcfg_periodic, .tcfg_initval, .timer_load, .timer_load_value
    );

    csr_timer u_timer (
        .clk, .reset, .timer_load, .timer_load_value,
        .tcfg_en, .tcfg_periodic, .tcfg_initval, .timer_value, .timer_zero
    );

    csr_scratch_regs #(.SAVE_COUNT(SAVE_COUNT)) u_scratch_regs (
        .clk, .reset, .csr_num, .csr_we, .csr_wmask, .csr_wvalue, .coreid_in,
        .save_data, .tid
    );

    csr_read_mux #(.SAVE_COUNT(SAVE_COUNT)) u_read_mux (
        .csr_num, .crmd_plv, .crmd_ie, .prmd_pplv, .prmd_pie, .ecfg_lie, .estat_is,
        .estat_ecode, .estat_esubcode, .era, .badv, .eentry, .save_data, .tid,
        .tcfg_en, .tcfg_periodic, .tcfg_initval, .timer_value, .csr_rvalue
    );

endmodule

`default_nettype wire

// File: tb/csr_vectors.svh
// Each row holds op, action CSR, mask or wb_pc, value or wb_vaddr, arg, read CSR,
// expected csr_rvalue, has_int and ex_entry. arg counts cycles for WAIT, holds {ipi, hw}
// for IRQ and ecode plus esubcode shifted by 6 for EX

task automatic load_vectors();
    // Reset values and masked writes
    add_row(RD, 14'h0, '0, '0, 0, CSR_TID, 32'h000000a5, 0, 32'h00000000);
    add_row(RD, 14'h0, '0, '0, 0, CSR_CRMD, 32'h00000000, 0, 32'h00000000);
    add_row(WRND, CSR_SAVE0, '0, '0, 0, CSR_SAVE0, '0, 0, 32'h00000000);
    add_row(WRND, CSR_SAVE0 + 14'd1, '0, '0, 0, CSR_SAVE0 + 14'd1, '0, 0, 32'h00000000);
    add_row(WRND, CSR_SAVE0 + 14'd2, '0, '0, 0, CSR_SAVE0 + 14'd2, '0, 0, 32'h00000000);
    add_row(WRND, CSR_SAVE0 + 14'd3, '0, '0, 0, CSR_SAVE0 + 14'd3, '0, 0, 32'h00000000);
    add_row(WRND, CSR_SAVE0, '0, '0, 0, CSR_SAVE0, '0, 0, 32'h00000000);
    add_row(RD, 14'h0, '0, '0, 0, CSR_SAVE0 + 14'd2, '0, 0, 32'h00000000);
    add_row(WR, CSR_EENTRY, '1, 32'h1c000fff, 0, CSR_EENTRY, 32'h1c000fc0, 0, 32'h1c000fc0);
    add_row(WR, CSR_EENTRY, 32'h0000ff00, 32'h12345678, 0, CSR_EENTRY, 32'h1c0056c0, 0,
            32'h1c0056c0);
    add_row(WR, CSR_ECFG, 32'h00001fff, 32'h00001fff, 0, CSR_ECFG, 32'h00001bff, 0, 32'h1c0056c0);
    add_row(WR, CSR_ECFG, 32'h00000400, '1, 0, CSR_ECFG, 32'h00001bff, 0, 32'h1c0056c0);
    // Exception entry with ALE, ADE/ADEM and ADE/ADEF
    add_row(WR, CSR_CRMD, '1, 32'h00000007, 0, CSR_CRMD, 32'h00000007, 0, 32'h1c0056c0);
    add_row(EX, 14'h0, 32'h1c001234, 32'h00008003, 9, CSR_ERA, 32'h1c001234, 0, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, CSR_BADV, 32'h00008003, 0, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, CSR_ESTAT, 32'h00090000, 0, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, CSR_PRMD, 32'h00000007, 0, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, CSR_CRMD, 32'h00000000, 0, 32'h1c0056c0);
    add_row(EX, 14'h0, 32'h1c001800, 32'h0badf00d, 'h48, CSR_BADV, 32'h0badf00d, 0, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, CSR_ESTAT, 32'h00480000, 0, 32'h1c0056c0);
    add_row(EX, 14'h0, 32'h1c002000, 32'hdeadbeef, 8, CSR_BADV, 32'h1c002000, 0, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, CSR_ESTAT, 32'h00080000, 0, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, CSR_ERA, 32'h1c002000, 0, 32'h1c0056c0);
    // Return restores PLV 1 and IE 1
    add_row(WR, CSR_PRMD, '1, 32'h00000005, 0, CSR_PRMD, 32'h00000005, 0, 32'h1c0056c0);
    add_row(RET, 14'h0, '0, '0, 0, CSR_CRMD, 32'h00000005, 0, 32'h1c0056c0);
    // Interrupt lines
    add_row(WR, CSR_ESTAT, 32'h3, 32'h2, 0, CSR_ESTAT, 32'h00080002, 1, 32'h1c0056c0);
    add_row(WR, CSR_ESTAT, 32'h3, 32'h0, 0, CSR_ESTAT, 32'h00080000, 0, 32'h1c0056c0);
    add_row(IRQ, 14'h0, '0, '0, 'h10, CSR_ESTAT, 32'h00080040, 1, 32'h1c0056c0);
    add_row(IRQ, 14'h0, '0, '0, 'h100, CSR_ESTAT, 32'h00081000, 1, 32'h1c0056c0);
    add_row(IRQ, 14'h0, '0, '0, 0, CSR_ESTAT, 32'h00080000, 0, 32'h1c0056c0);
    add_row(WR, CSR_CRMD, 32'h4, 32'h0, 0, CSR_CRMD, 32'h00000001, 0, 32'h1c0056c0);
    add_row(IRQ, 14'h0, '0, '0, 'h1ff, CSR_ESTAT, 32'h000813fc, 0, 32'h1c0056c0);
    add_row(WR, CSR_ESTAT, 32'h3, 32'h3, 0, CSR_ESTAT, 32'h000813ff, 0, 32'h1c0056c0);
    add_row(WR, CSR_ESTAT, 32'h3, 32'h0, 0, CSR_ESTAT, 32'h000813fc, 0, 32'h1c0056c0);
    add_row(IRQ, 14'h0, '0, '0, 0, CSR_ESTAT, 32'h00080000, 0, 32'h1c0056c0);
    // One-shot timer with initval 3
    add_row(WR, CSR_CRMD, 32'h4, 32'h4, 0, CSR_CRMD, 32'h00000005, 0, 32'h1c0056c0);
    add_row(WR, CSR_TCFG, '1, 32'h0000000d, 0, CSR_TVAL, 32'h0000000c, 0, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, CSR_TVAL, 32'h0000000b, 0, 32'h1c0056c0);
    add_row(WAIT, 14'h0, '0, '0, 12, CSR_ESTAT, 32'h00080800, 1, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, CSR_TVAL, 32'hffffffff, 1, 32'h1c0056c0);
    add_row(WR, CSR_TICLR, 32'h1, 32'h1, 0, CSR_ESTAT, 32'h00080000, 0, 32'h1c0056c0);
    add_row(WAIT, 14'h0, '0, '0, 5, CSR_TVAL, 32'hffffffff, 0, 32'h1c0056c0);
    // Periodic timer with initval 2
    add_row(WR, CSR_TCFG, '1, 32'h0000000b, 0, CSR_TVAL, 32'h00000008, 0, 32'h1c0056c0);
    add_row(WAIT, 14'h0, '0, '0, 9, CSR_TVAL, 32'h00000008, 1, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, CSR_ESTAT, 32'h00080800, 1, 32'h1c0056c0);
    add_row(WR, CSR_TICLR, 32'h1, 32'h1, 0, CSR_ESTAT, 32'h00080000, 0, 32'h1c0056c0);
    add_row(WAIT, 14'h0, '0, '0, 6, CSR_TVAL, 32'h00000008, 1, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, CSR_TCFG, 32'h0000000b, 1, 32'h1c0056c0);
    add_row(RD, 14'h0, '0, '0, 0, 14'h3ff, 32'h00000000, 1, 32'h1c0056c0);
endtask

// File: tb/csr_tb.sv
`default_nettype none

module csr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    localparam int        CLK_PERIOD = 20;
    localparam int        MAX_ROWS   = 64;
    localparam int        SAVE_COUNT = 4;
    localparam csr_word_t CORE_ID    = 32'h0000_00a5;

    // Row operations
    localparam int WR   = 0;
    localparam int WRND = 1;
    localparam int RD   = 2;
    localparam int EX   = 3;
    localparam int RET  = 4;
    localparam int IRQ  = 5;
    localparam int WAIT = 6;

    typedef struct {
        int        op;
        csr_num_t  num;
        csr_word_t mask;
        csr_word_t value;
        csr_word_t arg;
        csr_num_t  chk;
        csr_word_t exp_rvalue;
        logic      exp_int;
        csr_word_t exp_entry;
    } vec_t;

    logic                  clk;
    logic                  reset;
    csr_num_t              csr_num;
    logic                  csr_we;
    csr_word_t             csr_wmask;
    csr_word_t             csr_wvalue;
    logic                  wb_ex;
    ecode_t                wb_ecode;
    esubcode_t             wb_esubcode;
    csr_word_t             wb_pc;
    csr_word_t             wb_vaddr;
    logic                  ertn_flush;
    logic [HW_INT_NUM-1:0] hw_int_in;
    logic                  ipi_int_in;
    csr_word_t             coreid_in;
    csr_word_t             csr_rvalue;
    logic                  has_int;
    csr_word_t             ex_entry;

    vec_t   vecs [MAX_ROWS];
    int     n_vec = 0;
    integer seed;

    csr_top #(.SAVE_COUNT(SAVE_COUNT)) u_csr_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_row(input int op, input csr_num_t num, input csr_word_t mask,
                           input csr_word_t value, input int arg, input csr_num_t chk,
                           input csr_word_t exp_rvalue, input int exp_int,
                           input csr_word_t exp_entry);
        vecs[n_vec].op         = op;
        vecs[n_vec].num        = num;
        vecs[n_vec].mask       = mask;
        vecs[n_vec].value      = value;
        vecs[n_vec].arg        = arg;
        vecs[n_vec].chk        = chk;
        vecs[n_vec].exp_rvalue = exp_rvalue;
        vecs[n_vec].exp_int    = (exp_int != 0);
        vecs[n_vec].exp_entry  = exp_entry;
        n_vec++;
    endtask

    // Bitwise merge, mask bit one takes the new bit
    function automatic csr_word_t masked_update(input csr_word_t old_word,
                                                input csr_word_t mask, input csr_word_t data);
        csr_word_t result;
        for (int b = 0; b < 32; b++)
            result[b] = mask[b] ? data[b] : old_word[b];
        return result;
    endfunction

    // Random SAVE data, expected words follow a model of the array
    task automatic fill_random_rows();
        csr_word_t save_model [SAVE_COUNT];
        int        idx;
        for (int k = 0; k < SAVE_COUNT; k++)
            save_model[k] = '0;
        for (int i = 0; i < n_vec; i++) begin
            if (vecs[i].op == WRND) begin
                idx             = int'(vecs[i].num - CSR_SAVE0);
                vecs[i].mask    = $random(seed);
                vecs[i].value   = $random(seed);
                save_model[idx] = masked_update(save_model[idx], vecs[i].mask, vecs[i].value);
            end
            if (vecs[i].chk >= CSR_SAVE0 && vecs[i].chk < CSR_SAVE0 + 14'(SAVE_COUNT))
                vecs[i].exp_rvalue = save_model[int'(vecs[i].chk - CSR_SAVE0)];
        end
    endtask

    task automatic check_word(input int row, input string name, input csr_word_t got,
                              input csr_word_t exp);
        assert (got === exp)
        else begin
            $display("ERR row %0d %s got %h expected %h", row, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on row %0d", row);
        end
    endtask

    task automatic apply_row(input int i);
        vec_t v;
        v = vecs[i];
        case (v.op)
            WR, WRND: begin
                @(negedge clk);
                csr_num    = v.num;
                csr_we     = 1'b1;
                csr_wmask  = v.mask;
                csr_wvalue = v.value;
                @(negedge clk);
            end
            EX: begin
                @(negedge clk);
                wb_ex       = 1'b1;
                wb_ecode    = v.arg[5:0];
                wb_esubcode = v.arg[14:6];
                wb_pc       = v.mask;
                wb_vaddr    = v.value;
                @(negedge clk);
            end
            RET: begin
                @(negedge clk);
                ertn_flush = 1'b1;
                @(negedge clk);
            end
            IRQ: begin
                @(negedge clk);
                hw_int_in  = v.arg[HW_INT_NUM-1:0];
                ipi_int_in = v.arg[HW_INT_NUM];
                @(negedge clk);
            end
            RD: @(negedge clk);
            default: repeat (v.arg) @(negedge clk);
        endcase
        csr_we     = 1'b0;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
        csr_num    = v.chk;
        // Read mux settles well inside the low phase
        #(CLK_PERIOD / 4);
        check_word(i, "csr_rvalue", csr_rvalue, v.exp_rvalue);
        check_word(i, "has_int", {31'b0, has_int}, {31'b0, v.exp_int});
        check_word(i, "ex_entry", ex_entry, v.exp_entry);
    endtask

    initial begin
        reset       = 1'b1;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        ertn_flush  = 1'b0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        coreid_in   = CORE_ID;
        seed        = 89;
        load_vectors();
        fill_random_rows();
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < n_vec; i++)
            apply_row(i);
        $display("TESTS PASSED");
        $finish;
    end

    initial begin : watchdog
        int limit_cycles;
        wait (n_vec != 0);
        limit_cycles = n_vec * 64 + 10;
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the vector table did not finish within %0d cycles", limit_cycles);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    `include "csr_vectors.svh"

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
src/csr_addr_pkg.sv
src/csr_exc_pkg.sv
src/csr_exc_regs.sv
src/csr_int_ctrl.sv
src/csr_timer_cfg.sv
src/csr_timer.sv
src/csr_scratch_regs.sv
src/csr_read_mux.sv
src/csr_top.sv
tb/csr_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CSR testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module csr_tb -f vlog.f -o csr_sim
./obj_dir/csr_sim
